// ==== compile.f ====
hdl/pyramid_pkg.sv
hdl/pixel_mem_if.sv
hdl/frame_buffer.sv
hdl/gaussian_blur.sv
hdl/half_downsample.sv
hdl/pyramid_sequencer.sv
hdl/gaussian_pyramid.sv
test/pyramid_props.sv
test/tb_gaussian_pyramid.sv

// ==== hdl/frame_buffer.sv ====
`default_nettype none

module frame_buffer
    import pyramid_pkg::*;
#(
    parameter int DEPTH = O1_PIXELS
) (
    input  wire      clk_in,
    pixel_mem_if.mem mem
);

    pixel_t ram [DEPTH];

    // write port
    always_ff @(posedge clk_in) begin
        if (mem.wr_en) begin
            ram[mem.wr_addr[$clog2(DEPTH)-1:0]] <= mem.wr_data;
        end
    end

    // registered read, a same-cycle write is not seen yet
    always_ff @(posedge clk_in) begin
        if (mem.rd_en) begin
            mem.rd_data <= ram[mem.rd_addr[$clog2(DEPTH)-1:0]];
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gaussian_blur.sv ====
`default_nettype none

module gaussian_blur
    import pyramid_pkg::*;
#(
    parameter int WIDTH  = O1_WIDTH,
    parameter int HEIGHT = O1_HEIGHT
) (
    input  wire         clk_in,
    input  wire         rst_in,
    input  wire         start,
    output logic        rd_en,
    output addr_t       rd_addr,
    input  wire pixel_t rd_data,
    output logic        wr_en,
    output addr_t       wr_addr,
    output pixel_t      wr_data,
    output logic        done
);

    logic       busy;
    addr_t      x;              // output pixel being built
    addr_t      y;
    logic [1:0] tap_x;          // window position, 0..2 each way
    logic [1:0] tap_y;
    addr_t      sx;             // window tap after edge clamping
    addr_t      sy;

    // tags of the tap whose data is on rd_data this cycle
    logic       tap_vld;
    logic       tap_first;
    logic       tap_last;
    logic [1:0] tap_shift;      // log2 of the 1-2-1 x 1-2-1 weight
    addr_t      tap_pix;

    logic [PIXEL_BITS+4:0] tap_term;
    logic [PIXEL_BITS+4:0] acc;
    logic [PIXEL_BITS+4:0] sum;

    // clamp to the border
    always_comb begin
        if (tap_x == 2'd0) begin
            sx = (x == 0) ? x : x - 1'b1;
        end else if (tap_x == 2'd2) begin
            sx = (x == addr_t'(WIDTH - 1)) ? x : x + 1'b1;
        end else begin
            sx = x;
        end
        if (tap_y == 2'd0) begin
            sy = (y == 0) ? y : y - 1'b1;
        end else if (tap_y == 2'd2) begin
            sy = (y == addr_t'(HEIGHT - 1)) ? y : y + 1'b1;
        end else begin
            sy = y;
        end
    end

    assign rd_en   = busy;   // one tap read per cycle while running
    assign rd_addr = addr_t'(sy * WIDTH + sx);

    // raster walk, nine taps per output pixel
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy  <= 1'b0;
            x     <= '0;
            y     <= '0;
            tap_x <= '0;
            tap_y <= '0;
        end else if (!busy) begin
            if (start) begin
                busy  <= 1'b1;
                x     <= '0;
                y     <= '0;
                tap_x <= '0;
                tap_y <= '0;
            end
        end else if (tap_x != 2'd2) begin
            tap_x <= tap_x + 1'b1;
        end else begin
            tap_x <= '0;
            if (tap_y != 2'd2) begin
                tap_y <= tap_y + 1'b1;
            end else begin
                tap_y <= '0;
                if (x != addr_t'(WIDTH - 1)) begin
                    x <= x + 1'b1;
                end else begin
                    x <= '0;
                    if (y != addr_t'(HEIGHT - 1)) begin
                        y <= y + 1'b1;
                    end else begin
                        y    <= '0;
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    // tags follow the read by one cycle, like the data
    always_ff @(posedge clk_in) begin
        tap_first <= (tap_x == 2'd0) && (tap_y == 2'd0);
        tap_last  <= (tap_x == 2'd2) && (tap_y == 2'd2);
        tap_shift <= {1'b0, tap_x == 2'd1} + {1'b0, tap_y == 2'd1};
        tap_pix   <= addr_t'(y * WIDTH + x);
    end

    assign tap_term = {5'b0, rd_data} << tap_shift;
    assign sum      = (tap_first ? '0 : acc) + tap_term;

    always_ff @(posedge clk_in) begin
        if (tap_vld) begin
            acc <= sum;
        end
        if (tap_vld && tap_last) begin
            wr_addr <= tap_pix;
            wr_data <= pixel_t'((sum + 8) >> 4);   // weights total 16, round half up
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            tap_vld <= 1'b0;
            wr_en   <= 1'b0;
            done    <= 1'b0;
        end else begin
            tap_vld <= busy;
            wr_en   <= tap_vld && tap_last;
            done    <= wr_en && (wr_addr == addr_t'(WIDTH * HEIGHT - 1));
        end
    end

endmodule

`default_nettype wire

// ==== hdl/gaussian_pyramid.sv ====
`default_nettype none

module gaussian_pyramid
    import pyramid_pkg::*;
(
    input  wire         clk_in,
    input  wire         rst_in,
    input  wire         start_in,
    output logic        src_rd_en,
    output addr_t       src_addr,
    input  wire pixel_t src_pixel,
    output logic        layer_wr_en,
    output layer_t      layer_wr_sel,
    output addr_t       layer_wr_addr,
    output pixel_t      layer_wr_data,
    output logic        pyramid_done
);

    stage_t stage;
    logic   copy_wr_en;
    addr_t  copy_wr_addr;

    logic   blur1_start, blur1_rd_en, blur1_wr_en, blur1_done;
    addr_t  blur1_rd_addr, blur1_wr_addr;
    pixel_t blur1_wr_data;

    logic   down_start, down_rd_en, down_wr_en, down_done;
    addr_t  down_rd_addr, down_wr_addr;
    pixel_t down_wr_data;

    logic   blur2_start, blur2_rd_en, blur2_wr_en, blur2_done;
    addr_t  blur2_rd_addr, blur2_wr_addr;
    pixel_t blur2_wr_data;

    pixel_mem_if buf_o1_a ();   // O1L1
    pixel_mem_if buf_o1_b ();   // O1L2
    pixel_mem_if buf_o2_a ();   // O2L1
    pixel_mem_if buf_o2_b ();   // O2L2, write only

    frame_buffer #(.DEPTH(O1_PIXELS)) u_buf_o1_a (.clk_in(clk_in), .mem(buf_o1_a.mem));
    frame_buffer #(.DEPTH(O1_PIXELS)) u_buf_o1_b (.clk_in(clk_in), .mem(buf_o1_b.mem));
    frame_buffer #(.DEPTH(O2_PIXELS)) u_buf_o2_a (.clk_in(clk_in), .mem(buf_o2_a.mem));
    frame_buffer #(.DEPTH(O2_PIXELS)) u_buf_o2_b (.clk_in(clk_in), .mem(buf_o2_b.mem));

    pyramid_sequencer u_sequencer (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .start_in     (start_in),
        .stage        (stage),
        .src_rd_en    (src_rd_en),
        .src_addr     (src_addr),
        .copy_wr_en   (copy_wr_en),
        .copy_wr_addr (copy_wr_addr),
        .blur1_start  (blur1_start),
        .down_start   (down_start),
        .blur2_start  (blur2_start),
        .blur1_done   (blur1_done),
        .down_done    (down_done),
        .blur2_done   (blur2_done),
        .pyramid_done (pyramid_done)
    );

    gaussian_blur #(.WIDTH(O1_WIDTH), .HEIGHT(O1_HEIGHT)) u_blur_o1 (
        .clk_in(clk_in), .rst_in(rst_in), .start(blur1_start),
        .rd_en(blur1_rd_en), .rd_addr(blur1_rd_addr), .rd_data(buf_o1_a.rd_data),
        .wr_en(blur1_wr_en), .wr_addr(blur1_wr_addr), .wr_data(blur1_wr_data),
        .done(blur1_done)
    );

    half_downsample #(.SRC_WIDTH(O1_WIDTH), .SRC_HEIGHT(O1_HEIGHT)) u_down_o1_o2 (
        .clk_in(clk_in), .rst_in(rst_in), .start(down_start),
        .rd_en(down_rd_en), .rd_addr(down_rd_addr), .rd_data(buf_o1_b.rd_data),
        .wr_en(down_wr_en), .wr_addr(down_wr_addr), .wr_data(down_wr_data),
        .done(down_done)
    );

    gaussian_blur #(.WIDTH(O2_WIDTH), .HEIGHT(O2_HEIGHT)) u_blur_o2 (
        .clk_in(clk_in), .rst_in(rst_in), .start(blur2_start),
        .rd_en(blur2_rd_en), .rd_addr(blur2_rd_addr), .rd_data(buf_o2_a.rd_data),
        .wr_en(blur2_wr_en), .wr_addr(blur2_wr_addr), .wr_data(blur2_wr_data),
        .done(blur2_done)
    );

    // each buffer has a single producer and consumer, stage only opens the enables
    assign buf_o1_a.rd_addr = blur1_rd_addr;
    assign buf_o1_a.wr_addr = copy_wr_addr;
    assign buf_o1_a.wr_data = src_pixel;
    assign buf_o1_b.rd_addr = down_rd_addr;
    assign buf_o1_b.wr_addr = blur1_wr_addr;
    assign buf_o1_b.wr_data = blur1_wr_data;
    assign buf_o2_a.rd_addr = blur2_rd_addr;
    assign buf_o2_a.wr_addr = down_wr_addr;
    assign buf_o2_a.wr_data = down_wr_data;
    assign buf_o2_b.rd_en   = 1'b0;
    assign buf_o2_b.rd_addr = '0;
    assign buf_o2_b.wr_addr = blur2_wr_addr;
    assign buf_o2_b.wr_data = blur2_wr_data;

    always_comb begin
        buf_o1_a.rd_en = (stage == blur_o1l2) && blur1_rd_en;
        buf_o1_a.wr_en = (stage == copy_o1l1) && copy_wr_en;
        buf_o1_b.rd_en = (stage == down_o2l1) && down_rd_en;
        buf_o1_b.wr_en = (stage == blur_o1l2) && blur1_wr_en;
        buf_o2_a.rd_en = (stage == blur_o2l2) && blur2_rd_en;
        buf_o2_a.wr_en = (stage == down_o2l1) && down_wr_en;
        buf_o2_b.wr_en = (stage == blur_o2l2) && blur2_wr_en;
        // merge the active write onto the tagged layer port
        case (stage)
            copy_o1l1: begin
                layer_wr_en   = copy_wr_en;
                layer_wr_sel  = o1l1;
                layer_wr_addr = copy_wr_addr;
                layer_wr_data = src_pixel;
            end
            blur_o1l2: begin
                layer_wr_en   = blur1_wr_en;
                layer_wr_sel  = o1l2;
                layer_wr_addr = blur1_wr_addr;
                layer_wr_data = blur1_wr_data;
            end
            down_o2l1: begin
                layer_wr_en   = down_wr_en;
                layer_wr_sel  = o2l1;
                layer_wr_addr = down_wr_addr;
                layer_wr_data = down_wr_data;
            end
            blur_o2l2: begin
                layer_wr_en   = blur2_wr_en;
                layer_wr_sel  = o2l2;
                layer_wr_addr = blur2_wr_addr;
                layer_wr_data = blur2_wr_data;
            end
            default: begin
                layer_wr_en   = 1'b0;
                layer_wr_sel  = o1l1;
                layer_wr_addr = '0;
                layer_wr_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/half_downsample.sv ====
`default_nettype none

module half_downsample
    import pyramid_pkg::*;
#(
    parameter int SRC_WIDTH  = O1_WIDTH,
    parameter int SRC_HEIGHT = O1_HEIGHT
) (
    input  wire         clk_in,
    input  wire         rst_in,
    input  wire         start,
    output logic        rd_en,
    output addr_t       rd_addr,
    input  wire pixel_t rd_data,
    output logic        wr_en,
    output addr_t       wr_addr,
    output pixel_t      wr_data,
    output logic        done
);

    logic       busy;
    addr_t      x;          // coordinate in the half-size image
    addr_t      y;
    logic [1:0] tap;        // bit 0 picks the column, bit 1 the row

    logic       tap_vld;
    logic       tap_first;
    logic       tap_last;
    addr_t      tap_pix;

    logic [PIXEL_BITS+1:0] acc;
    logic [PIXEL_BITS+1:0] sum;

    assign rd_en   = busy;
    assign rd_addr = addr_t'((2 * y + tap[1]) * SRC_WIDTH + 2 * x + tap[0]);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            busy <= 1'b0;
            x    <= '0;
            y    <= '0;
            tap  <= '0;
        end else if (!busy) begin
            if (start) begin
                busy <= 1'b1;
                x    <= '0;
                y    <= '0;
                tap  <= '0;
            end
        end else begin
            tap <= tap + 1'b1;
            if (tap == 2'd3) begin   // block complete
                if (x != addr_t'(SRC_WIDTH / 2 - 1)) begin
                    x <= x + 1'b1;
                end else begin
                    x <= '0;
                    if (y != addr_t'(SRC_HEIGHT / 2 - 1)) begin
                        y <= y + 1'b1;
                    end else begin
                        y    <= '0;
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_in) begin
        tap_first <= (tap == 2'd0);
        tap_last  <= (tap == 2'd3);
        tap_pix   <= addr_t'(y * (SRC_WIDTH / 2) + x);
    end

    assign sum = (tap_first ? '0 : acc) + {2'b0, rd_data};

    always_ff @(posedge clk_in) begin
        if (tap_vld) begin
            acc <= sum;
        end
        if (tap_vld && tap_last) begin
            wr_addr <= tap_pix;
            wr_data <= pixel_t'((sum + 2) >> 2);   // mean of four, rounded
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            tap_vld <= 1'b0;
            wr_en   <= 1'b0;
            done    <= 1'b0;
        end else begin
            tap_vld <= busy;
            wr_en   <= tap_vld && tap_last;
            done    <= wr_en && (wr_addr == addr_t'((SRC_WIDTH / 2) * (SRC_HEIGHT / 2) - 1));
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pixel_mem_if.sv ====
`default_nettype none

interface pixel_mem_if
    import pyramid_pkg::*;
();
    logic   rd_en;
    addr_t  rd_addr;
    pixel_t rd_data;   // valid one cycle after rd_en
    logic   wr_en;
    addr_t  wr_addr;
    pixel_t wr_data;

    // routing side
    modport client (
        output rd_en,
        output rd_addr,
        input  rd_data,
        output wr_en,
        output wr_addr,
        output wr_data
    );

    modport mem (
        input  rd_en,
        input  rd_addr,
        output rd_data,
        input  wr_en,
        input  wr_addr,
        input  wr_data
    );

endinterface

`default_nettype wire

// ==== hdl/pyramid_pkg.sv ====
`default_nettype none

package pyramid_pkg;

    localparam int PIXEL_BITS = 8;

    // octave 1 is the source resolution
    localparam int O1_WIDTH  = 16;
    localparam int O1_HEIGHT = 16;
    localparam int O2_WIDTH  = O1_WIDTH / 2;   // each octave halves both sides
    localparam int O2_HEIGHT = O1_HEIGHT / 2;

    localparam int O1_PIXELS = O1_WIDTH * O1_HEIGHT;
    localparam int O2_PIXELS = O2_WIDTH * O2_HEIGHT;
    localparam int ADDR_BITS = $clog2(O1_PIXELS);   // octave 2 uses the low bits only

    localparam int SRC_READ_LATENCY = 2;   // external memory, enable to data

    typedef logic [PIXEL_BITS-1:0] pixel_t;
    typedef logic [ADDR_BITS-1:0]  addr_t;

    typedef enum logic [2:0] {
        idle,
        copy_o1l1,
        blur_o1l2,
        down_o2l1,
        blur_o2l2
    } stage_t;

    // tag on the shared layer write port
    typedef enum logic [1:0] {
        o1l1,
        o1l2,
        o2l1,
        o2l2
    } layer_t;

endpackage

`default_nettype wire

// ==== hdl/pyramid_sequencer.sv ====
`default_nettype none

module pyramid_sequencer
    import pyramid_pkg::*;
(
    input  wire    clk_in,
    input  wire    rst_in,
    input  wire    start_in,
    output stage_t stage,
    output logic   src_rd_en,
    output addr_t  src_addr,
    output logic   copy_wr_en,
    output addr_t  copy_wr_addr,
    output logic   blur1_start,
    output logic   down_start,
    output logic   blur2_start,
    input  wire    blur1_done,
    input  wire    down_done,
    input  wire    blur2_done,
    output logic   pyramid_done
);

    // source read enable and address, delayed to meet the returning pixel
    logic [SRC_READ_LATENCY-1:0] en_pipe;
    addr_t                       addr_pipe [SRC_READ_LATENCY];

    assign copy_wr_en   = en_pipe[SRC_READ_LATENCY-1];
    assign copy_wr_addr = addr_pipe[SRC_READ_LATENCY-1];

    always_ff @(posedge clk_in) begin
        addr_pipe[0] <= src_addr;
        for (int i = 1; i < SRC_READ_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            stage        <= idle;
            src_rd_en    <= 1'b0;
            src_addr     <= '0;
            en_pipe      <= '0;
            blur1_start  <= 1'b0;
            down_start   <= 1'b0;
            blur2_start  <= 1'b0;
            pyramid_done <= 1'b0;
        end else begin
            en_pipe      <= (en_pipe << 1) | SRC_READ_LATENCY'(src_rd_en);
            blur1_start  <= 1'b0;   // all starts and done are single pulses
            down_start   <= 1'b0;
            blur2_start  <= 1'b0;
            pyramid_done <= 1'b0;
            case (stage)
                idle: begin
                    if (start_in) begin
                        stage     <= copy_o1l1;
                        src_rd_en <= 1'b1;
                        src_addr  <= '0;
                    end
                end
                copy_o1l1: begin
                    // back-to-back reads over the whole source image
                    if (src_rd_en) begin
                        src_addr <= src_addr + 1'b1;
                        if (src_addr == addr_t'(O1_PIXELS - 1)) begin
                            src_rd_en <= 1'b0;
                        end
                    end
                    if (copy_wr_en && copy_wr_addr == addr_t'(O1_PIXELS - 1)) begin
                        stage       <= blur_o1l2;
                        blur1_start <= 1'b1;
                    end
                end
                blur_o1l2: begin
                    if (blur1_done) begin
                        stage      <= down_o2l1;
                        down_start <= 1'b1;
                    end
                end
                down_o2l1: begin
                    if (down_done) begin
                        stage       <= blur_o2l2;
                        blur2_start <= 1'b1;
                    end
                end
                blur_o2l2: begin
                    if (blur2_done) begin
                        stage        <= idle;
                        pyramid_done <= 1'b1;
                    end
                end
                default: stage <= idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== test/pyramid_props.sv ====
`default_nettype none

module pyramid_props
    import pyramid_pkg::*;
(
    input wire         clk_in,
    input wire         rst_in,
    input wire         start_in,
    input wire         layer_wr_en,
    input wire layer_t layer_wr_sel,
    input wire addr_t  layer_wr_addr,
    input wire         pyramid_done
);
    timeunit 1ns;
    timeprecision 1ps;

    logic started;            // first start_in seen since reset
    int   assert_errors = 0;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            started <= 1'b0;
        end else if (start_in) begin
            started <= 1'b1;
        end
    end

    done_single_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
        pyramid_done |=> !pyramid_done)
        else begin
            assert_errors++;
            $error("pyramid_done high for two cycles in a row");
        end

    // nothing is written before the first run
    quiet_before_start: assert property (@(posedge clk_in) disable iff (rst_in)
        !started |-> !layer_wr_en)
        else begin
            assert_errors++;
            $error("layer write before the first start_in");
        end

    o2_addr_range: assert property (@(posedge clk_in) disable iff (rst_in)
        layer_wr_en && (layer_wr_sel == o2l1 || layer_wr_sel == o2l2)
            |-> layer_wr_addr < addr_t'(O2_PIXELS))
        else begin
            assert_errors++;
            $error("octave 2 write at address %0d", layer_wr_addr);
        end

endmodule

`default_nettype wire

// ==== test/tb_gaussian_pyramid.sv ====
`default_nettype none

module tb_gaussian_pyramid
    import pyramid_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES    = 10;
    localparam int RUN_CYCLES      = O1_PIXELS + O1_PIXELS * 11 + O2_PIXELS * 5 + O2_PIXELS * 11;
    localparam int WATCHDOG_CYCLES = 2 * (2 * RUN_CYCLES + RESET_CYCLES);

    logic   clk_in = 1'b0;
    logic   rst_in;
    logic   start_in;
    logic   src_rd_en;
    addr_t  src_addr;
    pixel_t src_pixel;
    logic   layer_wr_en;
    layer_t layer_wr_sel;
    addr_t  layer_wr_addr;
    pixel_t layer_wr_data;
    logic   pyramid_done;

    pixel_t src_img [O1_PIXELS];
    pixel_t src_q;                      // first stage of the source read pipe
    pixel_t exp_px [4][O1_PIXELS];      // expected layers, indexed by tag
    logic   seen [4][O1_PIXELS];
    int     wr_count [4];
    int     src_reads;                  // source reads issued in this run
    int     done_count;
    int     last_tag;
    int     value_errors;
    int     other_errors;
    int     seed;

    always #5 clk_in = ~clk_in;

    gaussian_pyramid u_gaussian_pyramid (.*);

    bind gaussian_pyramid pyramid_props u_props (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .start_in      (start_in),
        .layer_wr_en   (layer_wr_en),
        .layer_wr_sel  (layer_wr_sel),
        .layer_wr_addr (layer_wr_addr),
        .pyramid_done  (pyramid_done)
    );

    // external source memory, data two cycles after the enable
    always @(posedge clk_in) begin
        if (src_rd_en) begin
            src_q <= src_img[src_addr];
        end
        src_pixel <= src_q;
    end

    function automatic int clamp(input int v, input int size);
        if (v < 0) return 0;
        if (v >= size) return size - 1;
        return v;
    endfunction

    function automatic int layer_size(input int tag);
        return (tag < 2) ? O1_PIXELS : O2_PIXELS;
    endfunction

    // 1-2-1 by 1-2-1 kernel, border pixels repeated
    function automatic pixel_t blur_ref(input int src, input int w, input int h,
                                        input int x, input int y);
        int sum;
        int weight;
        sum = 0;
        for (int dy = -1; dy <= 1; dy++) begin
            for (int dx = -1; dx <= 1; dx++) begin
                weight = (dx == 0 ? 2 : 1) * (dy == 0 ? 2 : 1);
                sum += weight * exp_px[src][clamp(y + dy, h) * w + clamp(x + dx, w)];
            end
        end
        return pixel_t'((sum + 8) >> 4);
    endfunction

    function automatic pixel_t down_ref(input int x, input int y);
        int sum;
        sum = 0;
        for (int dy = 0; dy < 2; dy++) begin
            for (int dx = 0; dx < 2; dx++) begin
                sum += exp_px[1][(2 * y + dy) * O1_WIDTH + 2 * x + dx];
            end
        end
        return pixel_t'((sum + 2) >> 2);
    endfunction

    task automatic prepare_image();
        for (int i = 0; i < O1_PIXELS; i++) begin
            src_img[i]   = pixel_t'($random(seed));
            exp_px[0][i] = src_img[i];
        end
        for (int y = 0; y < O1_HEIGHT; y++) begin
            for (int x = 0; x < O1_WIDTH; x++) begin
                exp_px[1][y * O1_WIDTH + x] = blur_ref(0, O1_WIDTH, O1_HEIGHT, x, y);
            end
        end
        for (int y = 0; y < O2_HEIGHT; y++) begin
            for (int x = 0; x < O2_WIDTH; x++) begin
                exp_px[2][y * O2_WIDTH + x] = down_ref(x, y);
            end
        end
        for (int y = 0; y < O2_HEIGHT; y++) begin
            for (int x = 0; x < O2_WIDTH; x++) begin
                exp_px[3][y * O2_WIDTH + x] = blur_ref(2, O2_WIDTH, O2_HEIGHT, x, y);
            end
        end
    endtask

    task automatic run_pyramid();
        int done_before;
        prepare_image();
        for (int t = 0; t < 4; t++) begin
            wr_count[t] = 0;
            for (int i = 0; i < O1_PIXELS; i++) begin
                seen[t][i] = 1'b0;
            end
        end
        last_tag    = 0;
        src_reads   = 0;
        done_before = done_count;
        @(posedge clk_in);
        start_in <= 1'b1;
        @(posedge clk_in);
        start_in <= 1'b0;
        repeat (600) @(posedge clk_in);   // well inside the first blur
        start_in <= 1'b1;                 // a busy pyramid ignores this
        @(posedge clk_in);
        start_in <= 1'b0;
        while (done_count == done_before) @(posedge clk_in);
        repeat (20) @(posedge clk_in);
        for (int t = 0; t < 4; t++) begin
            if (wr_count[t] != layer_size(t)) begin
                $display("layer %0d got %0d writes instead of %0d", t, wr_count[t],
                         layer_size(t));
                other_errors++;
            end
        end
        if (src_reads != O1_PIXELS) begin
            $display("source was read %0d times instead of %0d", src_reads, O1_PIXELS);
            other_errors++;
        end
        if (done_count != done_before + 1) begin
            $display("pyramid_done pulsed %0d times in one run", done_count - done_before);
            other_errors++;
        end
    endtask

    // compare every layer write against the expected layers
    always @(negedge clk_in) begin : check_writes
        int tag;
        // source reads walk the image once in ascending order
        if (!rst_in && src_rd_en) begin
            if (src_addr != addr_t'(src_reads)) begin
                $display("Fail at %0t: source address %0d, expected %0d", $time,
                         src_addr, src_reads);
                value_errors++;
            end
            src_reads++;
        end
        if (!rst_in && layer_wr_en) begin
            tag = int'(layer_wr_sel);
            if (tag < last_tag) begin
                $display("layer tag went back from %0d to %0d", last_tag, tag);
                other_errors++;
            end
            last_tag = tag;
            if (layer_wr_addr >= layer_size(tag)) begin
                $display("Fail at %0t: layer %0d address %0d out of range", $time, tag,
                         layer_wr_addr);
                value_errors++;
            end else begin
                if (seen[tag][layer_wr_addr]) begin
                    $display("layer %0d address %0d written twice", tag, layer_wr_addr);
                    other_errors++;
                end
                if (tag == 0 && layer_wr_addr != wr_count[0]) begin
                    $display("Fail at %0t: o1l1 address %0d, expected %0d", $time,
                             layer_wr_addr, wr_count[0]);
                    value_errors++;
                end
                if (layer_wr_data !== exp_px[tag][layer_wr_addr]) begin
                    $display("Fail at %0t: layer %0d addr %0d got %h expected %h", $time,
                             tag, layer_wr_addr, layer_wr_data, exp_px[tag][layer_wr_addr]);
                    value_errors++;
                end
                seen[tag][layer_wr_addr] = 1'b1;
            end
            wr_count[tag]++;
        end
        if (!rst_in && pyramid_done) begin
            done_count++;
            if (wr_count[3] != O2_PIXELS) begin
                $display("pyramid_done came before the last o2l2 write");
                other_errors++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_in);
        $display("timeout after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    initial begin : main
        int total;
        rst_in       = 1'b1;
        start_in     = 1'b0;
        src_pixel    = '0;
        seed         = 82;
        done_count   = 0;
        last_tag     = 0;
        src_reads    = 0;
        value_errors = 0;
        other_errors = 0;
        for (int t = 0; t < 4; t++) begin
            wr_count[t] = 0;
        end
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;
        repeat (5) @(posedge clk_in);
        run_pyramid();
        repeat (10) @(posedge clk_in);
        run_pyramid();   // fresh image, same DUT
        total = value_errors + other_errors + u_gaussian_pyramid.u_props.assert_errors;
        $display("errors: %0d value, %0d protocol, %0d assertion", value_errors,
                 other_errors, u_gaussian_pyramid.u_props.assert_errors);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
